// ==== fpu.f ====
logic/fp_pkg.sv
logic/fp_strobgen.sv
logic/fp_sequencer.sv
logic/fp_regfile.sv
logic/fp_alu.sv
logic/fpu.sv
tests/tb_clock.sv
tests/fpu_tb.sv

// ==== logic/fp_alu.sv ====
/*
	FPU arithmetic unit
	fixed-point add / subtract in one clock and a stepwise
	normalize of the mantissa with exponent tracking
*/

module fp_alu (
	input  logic             got_fp,
	input  logic             _0_f,
	input  logic             alu_go,
	input  fp_pkg::op_t      op,
	input  fp_pkg::fp_word_u opa,
	input  fp_pkg::fp_word_u opb,
	output fp_pkg::word_t    result,
	output fp_pkg::flags_t   flags,
	output logic             alu_busy
);

	import fp_pkg::*;

	word_t sum_w;
	logic ovf;
	fp_word_u work;
	logic nrm_zero;
	logic nrm_normal;
	logic nrm_limit;
	logic nrm_end;

	// two's complement add / subtract with signed overflow
	always_comb begin
		if (op == OP_SD) begin
			sum_w = opa.raw - opb.raw;
			ovf = (opa.raw[15] != opb.raw[15]) && (sum_w[15] != opa.raw[15]);
		end else begin
			sum_w = opa.raw + opb.raw;
			ovf = (opa.raw[15] == opb.raw[15]) && (sum_w[15] != opa.raw[15]);
		end
	end

	// normalize stop conditions on the working word
	assign nrm_zero = (work.f.mant == '0);
	assign nrm_normal = (work.f.mant[11] != work.f.mant[10]);
	// most negative exponent, no further shift possible
	assign nrm_limit = (work.f.exp == 4'b1000);
	assign nrm_end = nrm_zero | nrm_normal | nrm_limit;

	always_ff @(posedge got_fp) begin
		if (alu_go) begin
			case (op)
				OP_AD, OP_SD: begin
					result <= sum_w;
					flags <= '{z: (sum_w == '0), m: sum_w[15], v: ovf};
				end
				OP_NRF: begin
					work <= opa;
				end
				default: begin
					result <= '0;
					flags <= '{z: 1'b1, m: 1'b0, v: 1'b0};
				end
			endcase
		end else if (alu_busy) begin
			if (nrm_zero) begin
				result <= '0;
				flags <= '{z: 1'b1, m: 1'b0, v: 1'b0};
			end else if (nrm_normal) begin
				result <= work.raw;
				flags <= '{z: 1'b0, m: work.f.mant[11], v: 1'b0};
			end else if (nrm_limit) begin
				// keep the last valid word, flag the underflow
				result <= work.raw;
				flags <= '{z: 1'b0, m: work.f.mant[11], v: 1'b1};
			end else begin
				work.f.mant <= {work.f.mant[10:0], 1'b0};
				work.f.exp <= work.f.exp - 4'sd1;
			end
		end
	end

	// busy only for normalize, one clock per shift plus the final check
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			alu_busy <= 1'b0;
		else if (alu_go)
			alu_busy <= (op == OP_NRF);
		else if (alu_busy && nrm_end)
			alu_busy <= 1'b0;
	end

endmodule

// ==== logic/fp_pkg.sv ====
/*
	FPU control package
	word, address and LP counter types, opcodes, the float word
	view and the one-shot timing constants shared by the unit
*/

package fp_pkg;

	// memory and operand word
	typedef logic [15:0] word_t;

	// memory address
	typedef logic [15:0] addr_t;

	// operand fetch counter
	typedef logic [1:0] lp_t;

	// job opcodes, OP_NONE is answered with a zero result
	typedef enum logic [1:0] {
		OP_AD   = 2'd0,
		OP_SD   = 2'd1,
		OP_NRF  = 2'd2,
		OP_NONE = 2'd3
	} op_t;

	// mantissa in the high part, exponent in the low nibble
	typedef struct packed {
		logic signed [11:0] mant;
		logic signed [3:0]  exp;
	} fp_fields_t;

	// same word seen as plain integer or as float fields
	typedef union packed {
		word_t      raw;
		fp_fields_t f;
	} fp_word_u;

	// zero, minus, overflow / exponent underflow
	typedef struct packed {
		logic z;
		logic m;
		logic v;
	} flags_t;

	// start pulse length in clocks
	localparam int START_TICKS = 2;
	// minimum end pulse before the CPU ack may drop
	localparam int KC_TICKS = 3;

	// counter widths for the two one-shots
	localparam int START_W = $clog2(START_TICKS + 1);
	localparam int KC_W = $clog2(KC_TICKS + 1);

endpackage

// ==== logic/fp_regfile.sv ====
/*
	FPU operand registers
	A and B are loaded from memory as the LP counter steers,
	both cleared at job start
*/

module fp_regfile (
	input  logic             got_fp,
	input  logic             _0_f,
	input  fp_pkg::word_t    mem_data,
	input  logic             load_a,
	input  logic             load_b,
	input  logic             start,
	output fp_pkg::fp_word_u opa,
	output fp_pkg::fp_word_u opb
);

	// operand A, first word fetched
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			opa <= '0;
		else if (start)
			opa <= '0;
		else if (load_a)
			opa.raw <= mem_data;
	end

	// operand B, stays zero for one-word jobs
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			opb <= '0;
		else if (start)
			opb <= '0;
		else if (load_b)
			opb.raw <= mem_data;
	end

endmodule

// ==== logic/fp_sequencer.sv ====
/*
	FPU sequencer
	read / exec / end state flip-flops, LP operand counter,
	memory read handshake and the CPU acknowledge
*/

module fp_sequencer (
	input  logic          got_fp,
	input  logic          _0_f,
	input  logic          start,
	input  logic          strob1,
	input  logic          strob2,
	input  logic          cpu_req,
	input  fp_pkg::op_t   op,
	input  fp_pkg::addr_t base,
	input  logic          mem_ack,
	input  logic          alu_busy,
	output logic          mem_req,
	output fp_pkg::addr_t mem_addr,
	output logic          mem_wait,
	output fp_pkg::lp_t   lp,
	output logic          load_a,
	output logic          load_b,
	output logic          alu_go,
	output logic          done,
	output logic          cpu_ack
);

	import fp_pkg::*;

	logic f_read;
	logic f_exec;
	logic f_end;
	logic rd_busy;
	lp_t lp_need;
	logic words_done;
	logic rd_launch;
	logic rd_take;
	logic rd_close;
	logic alu_idle;
	logic kc_done;
	logic end_clear;
	logic [KC_W-1:0] kc_cnt;

	// number of words to fetch for this opcode
	always_comb begin
		case (op)
			OP_NRF:  lp_need = 2'd1;
			OP_NONE: lp_need = 2'd0;
			default: lp_need = 2'd2;
		endcase
	end

	assign words_done = (lp == lp_need);
	// strob2 launches a read, ack latches data, ack low closes it
	assign rd_launch = strob2 & f_read & ~rd_busy & ~words_done;
	assign rd_take = mem_req & mem_ack;
	assign rd_close = rd_busy & ~mem_req & ~mem_ack;
	assign alu_idle = ~alu_busy & ~alu_go;
	assign kc_done = (kc_cnt == KC_W'(KC_TICKS));
	assign end_clear = f_end & cpu_ack & kc_done & ~cpu_req;

	assign mem_addr = base + addr_t'(lp);
	assign mem_wait = rd_busy;
	assign load_a = rd_take & (lp == 2'd0);
	assign load_b = rd_take & (lp == 2'd1);
	assign done = f_end;

	// state flip-flops, advanced on strob1
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			f_read <= 1'b0;
			f_exec <= 1'b0;
			f_end <= 1'b0;
			alu_go <= 1'b0;
		end else begin
			alu_go <= 1'b0;
			if (start) begin
				f_read <= 1'b1;
				f_exec <= 1'b0;
				f_end <= 1'b0;
			end else if (strob1) begin
				if (f_read && words_done && !rd_busy) begin
					f_read <= 1'b0;
					f_exec <= 1'b1;
					alu_go <= 1'b1;
				end else if (f_exec && alu_idle) begin
					f_exec <= 1'b0;
					f_end <= 1'b1;
				end
			end else if (end_clear) begin
				// end state drops without a strobe, strobes are off here
				f_end <= 1'b0;
			end
		end
	end

	// memory read handshake and LP counter
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			mem_req <= 1'b0;
			rd_busy <= 1'b0;
			lp <= '0;
		end else begin
			if (start)
				lp <= '0;
			else if (rd_take)
				lp <= lp + 2'd1;

			if (rd_launch) begin
				mem_req <= 1'b1;
				rd_busy <= 1'b1;
			end else begin
				if (rd_take)
					mem_req <= 1'b0;
				if (rd_close)
					rd_busy <= 1'b0;
			end
		end
	end

	// end pulse length and CPU acknowledge
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			cpu_ack <= 1'b0;
			kc_cnt <= '0;
		end else begin
			cpu_ack <= f_end & ~end_clear;
			if (!f_end)
				kc_cnt <= '0;
			else if (!kc_done)
				kc_cnt <= kc_cnt + 1'b1;
		end
	end

endmodule

// ==== logic/fp_strobgen.sv ====
/*
	FPU strobe generator
	synchronizes the CPU request, produces the start pulse and
	then alternates strob1 / strob2 while a job runs
*/

module fp_strobgen (
	input  logic got_fp,
	input  logic _0_f,
	input  logic cpu_req,
	input  logic mem_wait,
	input  logic done,
	output logic start,
	output logic strob1,
	output logic strob2
);

	import fp_pkg::*;

	logic req_s1;
	logic arm;
	logic arm_d;
	logic [START_W-1:0] start_cnt;
	logic phase;
	logic active;

	// request sync and job arm flip-flop
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			req_s1 <= 1'b0;
			arm <= 1'b0;
			arm_d <= 1'b0;
		end else begin
			req_s1 <= cpu_req;
			// done wins, so a held request cannot re-arm
			if (done)
				arm <= 1'b0;
			else if (req_s1)
				arm <= 1'b1;
			arm_d <= arm;
		end
	end

	// start one-shot, fired on the arm rising edge
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			start_cnt <= '0;
		else if (arm && !arm_d)
			start_cnt <= START_W'(START_TICKS);
		else if (start_cnt != '0)
			start_cnt <= start_cnt - 1'b1;
	end

	assign start = (start_cnt != '0);

	// strobes run only after start has ended
	assign active = arm & arm_d & ~start & ~mem_wait & ~done;

	// phase restarts at strob1 after every stall
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			phase <= 1'b0;
		else
			phase <= active ? ~phase : 1'b0;
	end

	assign strob1 = active & ~phase;
	assign strob2 = active & phase;

endmodule

// ==== logic/fpu.sv ====
/*
	Floating-point coprocessor control unit
	CPU job handshake in, memory operand reads out, result and
	flags back to the CPU
*/

module fpu (
	input  logic           got_fp,
	input  logic           _0_f,
	// CPU side
	input  logic           cpu_req,
	input  fp_pkg::op_t    op,
	input  fp_pkg::addr_t  base,
	output logic           cpu_ack,
	output fp_pkg::word_t  result,
	output fp_pkg::flags_t flags,
	// memory side
	output logic           mem_req,
	output fp_pkg::addr_t  mem_addr,
	input  logic           mem_ack,
	input  fp_pkg::word_t  mem_data
);

	import fp_pkg::*;

	logic start;
	logic strob1;
	logic strob2;
	logic mem_wait;
	logic done;
	logic load_a;
	logic load_b;
	logic alu_go;
	logic alu_busy;
	fp_word_u opa;
	fp_word_u opb;

	fp_strobgen strobgen0 (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.cpu_req  (cpu_req),
		.mem_wait (mem_wait),
		.done     (done),
		.start    (start),
		.strob1   (strob1),
		.strob2   (strob2)
	);

	// LP only steers the address and load selects inside the sequencer
	fp_sequencer sequencer0 (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.start    (start),
		.strob1   (strob1),
		.strob2   (strob2),
		.cpu_req  (cpu_req),
		.op       (op),
		.base     (base),
		.mem_ack  (mem_ack),
		.alu_busy (alu_busy),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_wait (mem_wait),
		.lp       (),
		.load_a   (load_a),
		.load_b   (load_b),
		.alu_go   (alu_go),
		.done     (done),
		.cpu_ack  (cpu_ack)
	);

	fp_regfile regfile0 (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.mem_data (mem_data),
		.load_a   (load_a),
		.load_b   (load_b),
		.start    (start),
		.opa      (opa),
		.opb      (opb)
	);

	fp_alu alu0 (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.alu_go   (alu_go),
		.op       (op),
		.opa      (opa),
		.opb      (opb),
		.result   (result),
		.flags    (flags),
		.alu_busy (alu_busy)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module fpu_tb -Mdir "$OBJ" -f fpu.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/Vfpu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== tests/fpu_tb.sv ====
/*
	FPU testbench
	memory model with random ack delay, a table of jobs run
	through the CPU handshake, result, flag and address checks
*/

module fpu_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import fp_pkg::*;

	typedef struct packed {
		op_t    op;
		addr_t  base;
		word_t  w0;
		word_t  w1;
		word_t  res;
		flags_t fl;
	} row_t;

	localparam int N_ROWS = 15;
	localparam int ACK_TIMEOUT = 400;
	localparam int DROP_TIMEOUT = 50;
	localparam int RESET_TIMEOUT = 20;

	logic got_fp;
	logic _0_f;
	logic cpu_req;
	op_t op;
	addr_t base;
	logic cpu_ack;
	word_t result;
	flags_t flags;
	logic mem_req;
	addr_t mem_addr;
	logic mem_ack = 1'b0;
	word_t mem_data = '0;

	row_t rows [N_ROWS];
	addr_t reads [$];
	word_t cur_w0;
	word_t cur_w1;
	addr_t cur_base;
	int mem_state = 0;
	int mem_delay = 0;
	logic req_prev = 1'b0;

	tb_clock clk0 (
		.got_fp (got_fp),
		._0_f   (_0_f)
	);

	fpu dut0 (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.cpu_req  (cpu_req),
		.op       (op),
		.base     (base),
		.cpu_ack  (cpu_ack),
		.result   (result),
		.flags    (flags),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_ack  (mem_ack),
		.mem_data (mem_data)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flags(input string name, input flags_t got, input flags_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// words outside the current job read back as junk
	function automatic word_t read_word(input addr_t a);
		if (a == cur_base)
			return cur_w0;
		else if (a == cur_base + 16'd1)
			return cur_w1;
		else
			return a ^ 16'hC35A;
	endfunction

	// memory responder stepping once per falling edge
	always @(negedge got_fp) begin
		if (!_0_f) begin
			if (mem_req && !req_prev && mem_ack)
				abort_run("mem_req rose while mem_ack was still high");
			case (mem_state)
				0: begin
					if (mem_req) begin
						reads.push_back(mem_addr);
						mem_delay = $urandom_range(6, 0);
						mem_state = 1;
					end
				end
				1: begin
					if (!mem_req)
						abort_run("mem_req dropped before mem_ack came");
					if (mem_delay == 0) begin
						mem_data = read_word(mem_addr);
						mem_ack = 1'b1;
						mem_state = 2;
					end else begin
						mem_delay = mem_delay - 1;
					end
				end
				default: begin
					if (!mem_req) begin
						mem_ack = 1'b0;
						mem_data = ~mem_addr;
						mem_state = 0;
					end
				end
			endcase
			req_prev = mem_req;
		end
	end

	task automatic load_table();
		// op, base, word 0, word 1, result, flags {z, m, v}
		rows[0] = '{OP_AD, 16'h0010, 16'h1234, 16'h0111, 16'h1345, 3'b000};
		rows[1] = '{OP_AD, 16'h0200, 16'h7FFF, 16'h0001, 16'h8000, 3'b011};
		rows[2] = '{OP_SD, 16'h0300, 16'h0005, 16'h0007, 16'hFFFE, 3'b010};
		rows[3] = '{OP_SD, 16'h0400, 16'h4321, 16'h4321, 16'h0000, 3'b100};
		rows[4] = '{OP_SD, 16'h0500, 16'h8000, 16'h0001, 16'h7FFF, 3'b001};
		// second word wraps to 0 from a base at the top of memory
		rows[5] = '{OP_AD, 16'hFFFF, 16'hFFFF, 16'h0001, 16'h0000, 3'b100};
		rows[6] = '{OP_NRF, 16'h0600, 16'h0100, 16'hBEEF, 16'h400A, 3'b000};
		rows[7] = '{OP_NRF, 16'h0700, 16'h5A33, 16'hBEEF, 16'h5A33, 3'b000};
		rows[8] = '{OP_NRF, 16'h0800, 16'hFF02, 16'hBEEF, 16'h800B, 3'b010};
		rows[9] = '{OP_NRF, 16'h0900, 16'h0005, 16'hBEEF, 16'h0000, 3'b100};
		// exponent hits -8 before the mantissa is normal
		rows[10] = '{OP_NRF, 16'h0A00, 16'h001B, 16'hBEEF, 16'h0088, 3'b001};
		// normal exactly at exponent -8 without underflow
		rows[11] = '{OP_NRF, 16'h0B00, 16'h0021, 16'hBEEF, 16'h4008, 3'b000};
		rows[12] = '{OP_NONE, 16'h0C00, 16'h1111, 16'h2222, 16'h0000, 3'b100};
		rows[13] = '{OP_AD, 16'h0D00, 16'h8000, 16'h8000, 16'h0000, 3'b101};
		rows[14] = '{OP_SD, 16'h0E00, 16'h7000, 16'h9000, 16'hE000, 3'b011};
	endtask

	task automatic wait_ack(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (cpu_ack !== level) begin
			@(negedge got_fp);
			n++;
			if (n > limit)
				abort_run($sformatf("timeout: cpu_ack never %s", what));
		end
	endtask

	task automatic check_reset();
		int n;
		n = 0;
		while (_0_f !== 1'b0) begin
			@(negedge got_fp);
			n++;
			if (n > RESET_TIMEOUT)
				abort_run("timeout: reset was never released");
		end
		// nothing may move without a request
		repeat (3) begin
			@(negedge got_fp);
			check_bit("cpu_ack", cpu_ack, 1'b0);
			check_bit("mem_req", mem_req, 1'b0);
		end
	endtask

	task automatic run_job(input int i);
		row_t r;
		int hold;
		int nreads;
		r = rows[i];
		cur_base = r.base;
		cur_w0 = r.w0;
		cur_w1 = r.w1;
		reads.delete();
		@(negedge got_fp);
		op = r.op;
		base = r.base;
		cpu_req = 1'b1;
		wait_ack(1'b1, ACK_TIMEOUT, "rose");
		check_word("result", result, r.res);
		check_flags("flags", flags, r.fl);
		// outputs stay frozen while the CPU holds the request
		hold = $urandom_range(5, 0);
		repeat (hold) begin
			@(negedge got_fp);
			check_bit("cpu_ack", cpu_ack, 1'b1);
			check_word("result", result, r.res);
			check_flags("flags", flags, r.fl);
		end
		cpu_req = 1'b0;
		wait_ack(1'b0, DROP_TIMEOUT, "fell");
		check_bit("mem_req", mem_req, 1'b0);
		case (r.op)
			OP_NRF:  nreads = 1;
			OP_NONE: nreads = 0;
			default: nreads = 2;
		endcase
		if (reads.size() != nreads)
			abort_run($sformatf("job %0d made %0d memory reads instead of %0d",
				i, reads.size(), nreads));
		for (int k = 0; k < nreads; k++)
			check_addr("mem_addr", reads[k], r.base + addr_t'(k));
	endtask

	initial begin
		void'($urandom(89312));
		cpu_req = 1'b0;
		op = OP_NONE;
		base = '0;
		cur_base = '0;
		cur_w0 = '0;
		cur_w1 = '0;
		load_table();
		check_reset();
		for (int i = 0; i < N_ROWS; i++)
			run_job(i);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== tests/tb_clock.sv ====
/*
	testbench clock and reset
	4 ns clock, reset held high for the first 5 cycles
*/

module tb_clock (
	output logic got_fp,
	output logic _0_f
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		got_fp = 1'b0;
		forever #2 got_fp = ~got_fp;
	end

	initial begin
		_0_f = 1'b1;
		repeat (5) @(posedge got_fp);
		// released on a falling edge like the other inputs
		@(negedge got_fp);
		_0_f = 1'b0;
	end

endmodule
